//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = fetch_top_tb
FILELIST = fetch_top.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- design/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output fetch_pkg::addr_t      wb_adr,
    input  wire fetch_pkg::inst_t wb_rdata,
    input  wire                   wb_ack,
    output logic                  inst_valid,
    output fetch_pkg::inst_t      inst,
    output fetch_pkg::addr_t      inst_pc,
    input  wire                   inst_ready,
    input  wire                   redirect_valid,
    input  wire fetch_pkg::addr_t redirect_pc,
    input  wire fetch_pkg::addr_t pred_pc,
    input  wire                   stall_indirect
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_HOLD,
        S_WAIT
    } state_t;

    state_t           state;
    logic             cyc;
    logic             discard;  // Open cycle belongs to a stale path.
    fetch_pkg::addr_t pc;       // Address on the bus, then of the held word.
    fetch_pkg::addr_t next_pc;  // Target parked until the bus is free.
    fetch_pkg::inst_t word;
    logic             ack;

    assign ack = cyc && wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_FETCH;
            cyc     <= 1'b0;
            discard <= 1'b0;
            pc      <= fetch_pkg::RESET_PC;
            next_pc <= fetch_pkg::RESET_PC;
        end else begin
            case (state)
                S_FETCH: begin
                    if (ack) begin
                        if (redirect_valid || discard) begin
                            cyc     <= 1'b1; // Restart right away.
                            discard <= 1'b0;
                            pc      <= redirect_valid ? redirect_pc : next_pc;
                        end else begin
                            cyc   <= 1'b0;
                            state <= S_HOLD;
                        end
                    end else if (redirect_valid) begin
                        if (cyc) begin
                            discard <= 1'b1;
                            next_pc <= redirect_pc;
                        end else begin
                            cyc <= 1'b1;
                            pc  <= redirect_pc;
                        end
                    end else if (!cyc) begin
                        cyc <= 1'b1; // First request out of reset.
                        pc  <= next_pc;
                    end
                end
                S_HOLD: begin
                    if (redirect_valid) begin
                        state <= S_FETCH; // Held word is dropped.
                        cyc   <= 1'b1;
                        pc    <= redirect_pc;
                    end else if (inst_ready) begin
                        if (stall_indirect) begin
                            state <= S_WAIT;
                        end else begin
                            state <= S_FETCH;
                            cyc   <= 1'b1;
                            pc    <= pred_pc;
                        end
                    end
                end
                S_WAIT: begin
                    if (redirect_valid) begin
                        state <= S_FETCH;
                        cyc   <= 1'b1;
                        pc    <= redirect_pc;
                    end
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && ack) begin
            word <= wb_rdata;
        end
    end

    assign wb_cyc     = cyc;
    assign wb_stb     = cyc;
    assign wb_adr     = pc;
    assign inst_valid = (state == S_HOLD);
    assign inst       = word;
    assign inst_pc    = pc;

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [15:0] parcel_t;
    typedef logic [31:0] offset_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // Major opcodes of the 32-bit control transfers.
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // Quadrant 1 funct3 codes.
    localparam logic [2:0] C1_JAL  = 3'b001; // RV32 only.
    localparam logic [2:0] C1_J    = 3'b101;
    localparam logic [2:0] C1_BEQZ = 3'b110;
    localparam logic [2:0] C1_BNEZ = 3'b111;

endpackage

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire                   clk,
    input  wire                   rst,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output fetch_pkg::addr_t      wb_adr,
    input  wire fetch_pkg::inst_t wb_rdata,
    input  wire                   wb_ack,
    output logic                  inst_valid,
    output fetch_pkg::inst_t      inst,
    output fetch_pkg::addr_t      inst_pc,
    input  wire                   inst_ready,
    input  wire                   redirect_valid,
    input  wire fetch_pkg::addr_t redirect_pc
);

    fetch_pkg::addr_t pred_pc;
    logic             stall_indirect;

    predecode_if rv32_res ();
    predecode_if rvc_res ();

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_rdata       (wb_rdata),
        .wb_ack         (wb_ack),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_ready     (inst_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_pc        (pred_pc),
        .stall_indirect (stall_indirect)
    );

    rv32_predecode u_rv32 (
        .word (inst),
        .res  (rv32_res.producer)
    );

    // The compressed parcel is the low half of the held word.
    rvc_predecode u_rvc (
        .parcel (inst[15:0]),
        .res    (rvc_res.producer)
    );

    next_pc_select u_sel (
        .pc             (inst_pc),
        .word           (inst),
        .rv32_res       (rv32_res.consumer),
        .rvc_res        (rvc_res.consumer),
        .pred_pc        (pred_pc),
        .stall_indirect (stall_indirect)
    );

endmodule

`default_nettype wire

//--- design/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  wire fetch_pkg::addr_t pc,
    input  wire fetch_pkg::inst_t word,
    predecode_if.consumer         rv32_res,
    predecode_if.consumer         rvc_res,
    output fetch_pkg::addr_t      pred_pc,
    output logic                  stall_indirect
);

    logic               is_32;
    logic               is_jump;
    logic               is_branch;
    logic               taken;
    fetch_pkg::offset_t offset;
    fetch_pkg::addr_t   len;

    assign is_32 = (word[1:0] == 2'b11);

    always_comb begin
        if (is_32) begin
            is_jump        = rv32_res.is_jump;
            is_branch      = rv32_res.is_branch;
            stall_indirect = rv32_res.is_indirect;
            offset         = rv32_res.offset;
            len            = 32'd4;
        end else begin
            is_jump        = rvc_res.is_jump;
            is_branch      = rvc_res.is_branch;
            stall_indirect = rvc_res.is_indirect;
            offset         = rvc_res.offset;
            len            = 32'd2;
        end
    end

    // Backward branches taken, forward ones not.
    assign taken = is_jump || (is_branch && offset[31]);

    assign pred_pc = taken ? (pc + offset) : (pc + len);

endmodule

`default_nettype wire

//--- design/predecode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface predecode_if;

    logic              is_jump;     // Unconditional, pc-relative.
    logic              is_branch;   // Conditional, pc-relative.
    logic              is_indirect; // Target comes from a register.
    fetch_pkg::offset_t offset;

    modport producer (
        output is_jump,
        output is_branch,
        output is_indirect,
        output offset
    );

    modport consumer (
        input is_jump,
        input is_branch,
        input is_indirect,
        input offset
    );

endinterface

`default_nettype wire

//--- design/rv32_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_predecode (
    input wire fetch_pkg::inst_t word,
    predecode_if.producer         res
);

    fetch_pkg::offset_t j_imm;
    fetch_pkg::offset_t b_imm;
    logic [6:0]         opcode;

    assign opcode = word[6:0];

    // J-type immediate with bit 0 always zero.
    assign j_imm = {
        {11{word[31]}},
        word[31],
        word[19:12],
        word[20],
        word[30:21],
        1'b0
    };

    // B-type immediate.
    assign b_imm = {
        {19{word[31]}},
        word[31],
        word[7],
        word[30:25],
        word[11:8],
        1'b0
    };

    always_comb begin
        res.is_jump     = 1'b0;
        res.is_branch   = 1'b0;
        res.is_indirect = 1'b0;
        res.offset      = j_imm;
        case (opcode)
            fetch_pkg::OP_JAL: begin
                res.is_jump = 1'b1;
            end
            fetch_pkg::OP_BRANCH: begin
                res.is_branch = 1'b1;
                res.offset    = b_imm;
            end
            fetch_pkg::OP_JALR: begin
                res.is_indirect = 1'b1; // Target unknown here.
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/rvc_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_predecode (
    input wire fetch_pkg::parcel_t parcel,
    predecode_if.producer           res
);

    logic [1:0]         quadrant;
    logic [2:0]         funct3;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    fetch_pkg::offset_t cj_imm;
    fetch_pkg::offset_t cb_imm;

    assign quadrant = parcel[1:0];
    assign funct3   = parcel[15:13];
    assign rs1      = parcel[11:7];
    assign rs2      = parcel[6:2];

    // CJ format holds imm[11|4|9:8|10|6|7|3:1|5] in bits 12 to 2.
    assign cj_imm = {
        {20{parcel[12]}},
        parcel[12],
        parcel[8],
        parcel[10:9],
        parcel[6],
        parcel[7],
        parcel[2],
        parcel[11],
        parcel[5:3],
        1'b0
    };

    // CB format holds imm[8|4:3] in bits 12 to 10 and imm[7:6|2:1|5] in bits 6 to 2.
    assign cb_imm = {
        {23{parcel[12]}},
        parcel[12],
        parcel[6:5],
        parcel[2],
        parcel[11:10],
        parcel[4:3],
        1'b0
    };

    always_comb begin
        res.is_jump     = 1'b0;
        res.is_branch   = 1'b0;
        res.is_indirect = 1'b0;
        res.offset      = cj_imm;
        if (quadrant == 2'b01) begin
            case (funct3)
                fetch_pkg::C1_J,
                fetch_pkg::C1_JAL: begin
                    res.is_jump = 1'b1;
                end
                fetch_pkg::C1_BEQZ,
                fetch_pkg::C1_BNEZ: begin
                    res.is_branch = 1'b1;
                    res.offset    = cb_imm;
                end
                default: begin
                end
            endcase
        end else if (quadrant == 2'b10 && funct3 == 3'b100) begin
            // C.JR and C.JALR; rs2 set means C.MV or C.ADD instead.
            res.is_indirect = (rs2 == 5'd0) && (rs1 != 5'd0);
        end
    end

endmodule

`default_nettype wire

//--- dv/fetch_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top_tb;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_ROWS   = 18;

    typedef struct packed {
        fetch_pkg::addr_t addr;   // Expected request address.
        fetch_pkg::inst_t word;   // Returned by the slave.
        fetch_pkg::addr_t next;   // Expected next request.
        fetch_pkg::addr_t redir;  // Back-end redirect target or zero.
        logic             in_bus; // Redirect while the bus cycle is open.
    } row_t;

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    fetch_pkg::addr_t wb_adr;
    fetch_pkg::inst_t wb_rdata;
    logic             wb_ack;
    logic             inst_valid;
    fetch_pkg::inst_t inst;
    fetch_pkg::addr_t inst_pc;
    logic             inst_ready;
    logic             redirect_valid;
    fetch_pkg::addr_t redirect_pc;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state = 32'h90c0ce1c;

    fetch_top UUT (.*);

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_held(input row_t row);
        check_value("inst_valid", 32'(inst_valid), 32'd1);
        check_value("inst", inst, row.word);
        check_value("inst_pc", inst_pc, row.addr);
        check_value("wb_cyc", 32'(wb_cyc), 32'd0); // No request under back-pressure.
    endtask

    task automatic load_table();
        rows[0]  = '{32'h000, 32'h0000_0013, 32'h004, 32'h000, 1'b0};
        rows[1]  = '{32'h004, 32'h0013_0001, 32'h006, 32'h000, 1'b0}; // C.NOP
        rows[2]  = '{32'h006, 32'h0000_0013, 32'h00a, 32'h000, 1'b0};
        rows[3]  = '{32'h00a, 32'h0000_0085, 32'h00c, 32'h000, 1'b0}; // C.ADDI
        rows[4]  = '{32'h00c, 32'h0400_006f, 32'h04c, 32'h000, 1'b0}; // JAL +0x40
        rows[5]  = '{32'h04c, 32'h0000_b7c5, 32'h02c, 32'h000, 1'b0}; // C.J -0x20
        rows[6]  = '{32'h02c, 32'h0000_2801, 32'h03c, 32'h000, 1'b0}; // C.JAL +0x10
        rows[7]  = '{32'h03c, 32'hff9f_f06f, 32'h034, 32'h000, 1'b0}; // JAL -8
        rows[8]  = '{32'h034, 32'hfe00_08e3, 32'h024, 32'h000, 1'b0}; // BEQ -0x10
        rows[9]  = '{32'h024, 32'h0200_1063, 32'h028, 32'h000, 1'b0}; // BNE +0x20
        rows[10] = '{32'h028, 32'h0000_dc6d, 32'h022, 32'h000, 1'b0}; // C.BEQZ -6
        rows[11] = '{32'h022, 32'h0000_e401, 32'h024, 32'h000, 1'b0}; // C.BNEZ +8
        rows[12] = '{32'h024, 32'h0000_8067, 32'h100, 32'h100, 1'b0}; // JALR
        rows[13] = '{32'h100, 32'h0000_8082, 32'h202, 32'h202, 1'b0}; // C.JR
        rows[14] = '{32'h202, 32'h0000_9282, 32'h300, 32'h300, 1'b0}; // C.JALR
        rows[15] = '{32'h300, 32'h0000_0013, 32'h400, 32'h400, 1'b1};
        rows[16] = '{32'h400, 32'h0000_808a, 32'h402, 32'h000, 1'b0}; // C.MV
        rows[17] = '{32'h402, 32'h0000_0013, 32'h406, 32'h000, 1'b0};
    endtask

    task automatic run_row(input row_t row);
        while (!wb_cyc) @(negedge clk);
        check_value("wb_adr", wb_adr, row.addr);
        check_value("wb_stb", 32'(wb_stb), 32'd1);
        if (row.in_bus) begin
            redirect_valid = 1'b1;
            redirect_pc    = row.redir;
            @(negedge clk);
            redirect_valid = 1'b0;
        end
        repeat (rand_below(4)) begin
            @(negedge clk);
            check_value("wb_adr", wb_adr, row.addr); // Held until ack.
        end
        wb_ack   = 1'b1;
        wb_rdata = row.word;
        @(negedge clk);
        wb_ack = 1'b0;
        if (row.in_bus) begin
            check_value("inst_valid", 32'(inst_valid), 32'd0); // Word discarded.
        end else begin
            check_held(row);
            repeat (rand_below(3)) begin
                @(negedge clk);
                check_held(row);
            end
            inst_ready = 1'b1;
            @(negedge clk);
            inst_ready = 1'b0;
            if (row.redir != 32'h0) begin
                // The bus stays idle until the back end sends the indirect target.
                repeat (2) begin
                    check_value("wb_cyc", 32'(wb_cyc), 32'd0);
                    check_value("inst_valid", 32'(inst_valid), 32'd0);
                    @(negedge clk);
                end
                redirect_valid = 1'b1;
                redirect_pc    = row.redir;
                @(negedge clk);
                redirect_valid = 1'b0;
            end
        end
        check_value("wb_cyc", 32'(wb_cyc), 32'd1);
        check_value("wb_adr", wb_adr, row.next);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_ROWS * 20 + 10) * CLK_PERIOD);
        $display("timeout: the fetch sequence did not finish in time");
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        rst            = 1'b1;
        wb_rdata       = '0;
        wb_ack         = 1'b0;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_table();
        repeat (4) begin
            @(negedge clk);
            check_value("wb_cyc", 32'(wb_cyc), 32'd0);
            check_value("wb_stb", 32'(wb_stb), 32'd0);
            check_value("inst_valid", 32'(inst_valid), 32'd0);
        end
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.f
design/fetch_pkg.sv
design/predecode_if.sv
design/rv32_predecode.sv
design/rvc_predecode.sv
design/next_pc_select.sv
design/fetch_ctrl.sv
design/fetch_top.sv
dv/fetch_top_tb.sv
